// File: verilog/norm_pkg.sv
////////////////////////////////////////////////////////////
// FP32 and NaN-boxed FP16 only; exponent arrives signed and biased
// Mantissa in has two integer bits, 23 fraction bits, 3 extra low bits
////////////////////////////////////////////////////////////

package norm_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////
  localparam int unsigned EXP_W     = 8;           // FP32 exponent
  localparam int unsigned MANT_W    = 23;          // FP32 fraction
  localparam int unsigned EXP_W_H   = 5;           // FP16 exponent
  localparam int unsigned MANT_W_H  = 10;          // FP16 fraction
  localparam int unsigned MANT_IN_W = MANT_W + 5;  // Unnormalized mantissa
  localparam int unsigned EXP_IN_W  = EXP_W + 2;   // Signed exponent in
  localparam int unsigned MAIN_W    = MANT_W + 1;  // Significand with hidden bit
  localparam int unsigned TAIL_W    = 5;           // Bits kept below FP32 LSB
  localparam int unsigned RES_W     = 32;
  localparam int unsigned HALF_W    = 16;          // NaN-box fill for FP16

  // Denormal right shift, clamped once all bits reach the sticky pad
  localparam int unsigned RS_SH_W   = 5;
  localparam int unsigned RS_PAD_W  = 2 ** RS_SH_W;

  // Overflow thresholds, exponent field all ones
  localparam logic signed [EXP_IN_W-1:0] EXP_MAX   = (2 ** EXP_W) - 1;
  localparam logic signed [EXP_IN_W-1:0] EXP_MAX_H = (2 ** EXP_W_H) - 1;

  // Quiet NaN fraction, MSB only
  localparam logic [MANT_W-1:0] MANT_NAN = {1'b1, {(MANT_W-1){1'b0}}};

  ////////////////////////////////////////////////////////////
  // Rounding modes and flag positions
  ////////////////////////////////////////////////////////////
  localparam logic [2:0] RM_NEAREST  = 3'd0;
  localparam logic [2:0] RM_TRUNC    = 3'd1;
  localparam logic [2:0] RM_MINUSINF = 3'd2;
  localparam logic [2:0] RM_PLUSINF  = 3'd3;

  localparam int unsigned FLAG_NV = 4;
  localparam int unsigned FLAG_DZ = 3;
  localparam int unsigned FLAG_OF = 2;
  localparam int unsigned FLAG_UF = 1;
  localparam int unsigned FLAG_NX = 0;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic nan_a;
    logic nan_b;
    logic snan;    // Either NaN is signalling
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
  } operand_class_t;

  typedef struct packed {
    logic [MANT_IN_W-1:0]       mant;
    logic signed [EXP_IN_W-1:0] exp;
    logic                       sign;
    logic                       op_sqrt;  // 0 is divide
    logic                       fp16;
    logic [2:0]                 rm;
    operand_class_t             cls;
  } norm_req_t;

  typedef struct packed {
    logic [RES_W-1:0] result;
    logic [4:0]       fflags;  // NV DZ OF UF NX
  } norm_res_t;

  typedef struct packed {
    logic active;  // Special result overrides datapath
    logic sign;
    logic nan;
    logic inf;
    logic nv;
    logic dz;
    logic of;
  } special_t;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [MAIN_W-1:0] mant_main;
    logic [TAIL_W-1:0] mant_tail;
    logic              uf;
    logic              of;
  } norm_out_t;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [MANT_W-1:0] frac;  // FP16 fraction sits in the top bits
    logic              inexact;
    logic              uf;
    logic              of;
  } round_out_t;

endpackage

// File: verilog/pipe_stage.sv
////////////////////////////////////////////////////////////
// One register stage, no stall; payload loads every cycle
////////////////////////////////////////////////////////////

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_in,
  input  payload_t data_in,
  output logic     valid_out,
  output payload_t data_out
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_out <= 1'b0;
      data_out  <= '0;    // Output reads zero after reset
    end
    else
    begin
      valid_out <= valid_in;
      data_out  <= data_in;  // Invalid cycles load too
    end
  end

endmodule

// File: verilog/special_case_check.sv
////////////////////////////////////////////////////////////
// Operand class flags come from the front end and are trusted
// Divide by infinity returns signed zero with OF set
////////////////////////////////////////////////////////////

module special_case_check (
  input  norm_pkg::norm_req_t req,
  output norm_pkg::special_t  spec
);

  logic is_div;

  assign is_div = ~req.op_sqrt;

  ////////////////////////////////////////////////////////////
  // Priority chain, first match wins
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    // Defaults, no special case
    spec        = '0;
    spec.sign   = req.sign;

    if (req.cls.nan_a)
    begin
      spec.active = 1'b1;
      spec.nan    = 1'b1;
      spec.nv     = req.cls.snan;  // Only signalling NaN raises NV
    end
    else if (is_div && req.cls.nan_b)
    begin
      spec.active = 1'b1;
      spec.nan    = 1'b1;
      spec.nv     = req.cls.snan;
    end
    else if (req.cls.inf_a)
    begin
      spec.active = 1'b1;
      if (is_div && req.cls.inf_b)  // inf/inf
      begin
        spec.nan = 1'b1;
        spec.nv  = 1'b1;
      end
      else if (req.op_sqrt && req.sign)  // sqrt(-inf)
      begin
        spec.nan = 1'b1;
        spec.nv  = 1'b1;
      end
      else
      begin
        spec.inf = 1'b1;
        spec.of  = 1'b1;
      end
    end
    else if (is_div && req.cls.inf_b)
    begin
      // x/inf, signed zero
      spec.active = 1'b1;
      spec.of     = 1'b1;
    end
    else if (req.cls.zero_a)
    begin
      spec.active = 1'b1;
      if (is_div && req.cls.zero_b)  // 0/0
      begin
        spec.nan = 1'b1;
        spec.nv  = 1'b1;
        spec.dz  = 1'b1;
      end
    end
    else if (is_div && req.cls.zero_b)
    begin
      spec.active = 1'b1;
      spec.inf    = 1'b1;
      spec.dz     = 1'b1;  // x/0
    end
    else if (req.op_sqrt && req.sign)
    begin
      spec.active = 1'b1;
      spec.nan    = 1'b1;
      spec.nv     = 1'b1;  // sqrt of negative number
    end

    // Canonical NaN is always positive
    if (spec.nan)
      spec.sign = 1'b0;
  end

endmodule

// File: verilog/norm_shift.sv
////////////////////////////////////////////////////////////
// Exponent must already be biased for the selected format
// Right shift clamps once every bit lands in the sticky pad
////////////////////////////////////////////////////////////

module norm_shift (
  input  norm_pkg::norm_req_t req,
  output norm_pkg::norm_out_t norm
);

  logic [norm_pkg::MAIN_W-1:0]                    mant_one;   // 1.xxx alignment
  logic [norm_pkg::MAIN_W-1:0]                    mant_half;  // 0.1xx alignment
  logic [norm_pkg::EXP_W-1:0]                     exp_dec;
  logic signed [norm_pkg::EXP_IN_W-1:0]           exp_lim;
  logic [norm_pkg::EXP_IN_W-1:0]                  rs_amt;
  logic [norm_pkg::RS_SH_W-1:0]                   rs_sh;
  logic [norm_pkg::MANT_IN_W+norm_pkg::RS_PAD_W-1:0] rs_vec;
  logic                                           top_bit;

  assign top_bit   = req.mant[norm_pkg::MANT_IN_W-1];
  assign mant_one  = req.mant[norm_pkg::MANT_IN_W-1 -: norm_pkg::MAIN_W];
  assign mant_half = req.mant[norm_pkg::MANT_IN_W-2 -: norm_pkg::MAIN_W];
  assign exp_dec   = req.exp[norm_pkg::EXP_W-1:0] - 1'b1;

  // Overflow limit per format
  assign exp_lim = req.fp16 ? norm_pkg::EXP_MAX_H : norm_pkg::EXP_MAX;

  ////////////////////////////////////////////////////////////
  // Denormal right shift by (1 - exp)
  ////////////////////////////////////////////////////////////
  assign rs_amt = 1 - req.exp;  // Meaningful only for negative exp
  assign rs_sh  = (rs_amt > norm_pkg::RS_PAD_W - 1) ? '1 : rs_amt[norm_pkg::RS_SH_W-1:0];
  assign rs_vec = {req.mant, {norm_pkg::RS_PAD_W{1'b0}}} >> rs_sh;

  ////////////////////////////////////////////////////////////
  // Exponent classification
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    norm      = '0;
    norm.sign = req.sign;

    if (req.exp == '0)
    begin
      if (req.mant != '0)
      begin
        // Denormal, one place right
        norm.mant_main = {1'b0, req.mant[norm_pkg::MANT_IN_W-1 -: norm_pkg::MANT_W]};
        norm.mant_tail = req.mant[norm_pkg::TAIL_W-1:0];
        norm.uf        = 1'b1;
      end
      // Zero mantissa stays an exact zero
    end
    else if ((req.exp == 1) && !top_bit)
    begin
      norm.mant_main = mant_one;  // 0.1xx at exp 1 is denormal
      norm.mant_tail = {req.mant[norm_pkg::TAIL_W-2:0], 1'b0};
      norm.uf        = 1'b1;
    end
    else if (req.exp < 0)
    begin
      // Shifted-out bits fold into the tail LSB
      norm.mant_main = rs_vec[norm_pkg::MANT_IN_W+norm_pkg::RS_PAD_W-1 -: norm_pkg::MAIN_W];
      norm.mant_tail = {rs_vec[norm_pkg::RS_PAD_W+norm_pkg::TAIL_W-2 -: norm_pkg::TAIL_W-1],
                        |rs_vec[norm_pkg::RS_PAD_W-1:0]};
      norm.uf        = 1'b1;
    end
    else if (req.exp >= exp_lim)
    begin
      norm.exp = '1;  // Infinity, low bits cover FP16
      norm.of  = 1'b1;
    end
    else if (!top_bit)
    begin
      norm.mant_main = mant_half;  // 0.1xx, one left
      norm.mant_tail = {req.mant[norm_pkg::TAIL_W-3:0], 2'b00};
      norm.exp       = exp_dec;
    end
    else
    begin
      norm.mant_main = mant_one;   // Already 1.xxx
      norm.mant_tail = {req.mant[norm_pkg::TAIL_W-2:0], 1'b0};
      norm.exp       = req.exp[norm_pkg::EXP_W-1:0];
    end
  end

endmodule

// File: verilog/round_unit.sv
////////////////////////////////////////////////////////////
// FP16 guard and sticky come only from the shared significand
// Carry out renormalizes; a denormal carry keeps exponent zero
////////////////////////////////////////////////////////////

module round_unit (
  input  norm_pkg::norm_out_t  norm,
  input  logic [2:0]           rm,
  input  logic                 fp16,
  output norm_pkg::round_out_t rnd
);

  logic [norm_pkg::MAIN_W-1:0] upper;  // Significand kept for the format
  logic [norm_pkg::MAIN_W-1:0] ulp;    // One unit in the last place
  logic [norm_pkg::MAIN_W:0]   sum;
  logic                        guard;
  logic                        rbit;
  logic                        sticky;
  logic                        lsb;
  logic                        inexact;
  logic                        round_up;
  logic                        carry;

  ////////////////////////////////////////////////////////////
  // Guard, round and sticky per format
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    if (fp16)
    begin
      // 11-bit significand at the top of mant_main
      upper  = {norm.mant_main[norm_pkg::MANT_W -: norm_pkg::MANT_W_H+1],
                {(norm_pkg::MANT_W-norm_pkg::MANT_W_H){1'b0}}};
      ulp    = {{norm_pkg::MANT_W_H{1'b0}}, 1'b1,
                {(norm_pkg::MANT_W-norm_pkg::MANT_W_H){1'b0}}};
      lsb    = norm.mant_main[norm_pkg::MANT_W-norm_pkg::MANT_W_H];
      guard  = norm.mant_main[norm_pkg::MANT_W-norm_pkg::MANT_W_H-1];
      rbit   = norm.mant_main[norm_pkg::MANT_W-norm_pkg::MANT_W_H-2];
      sticky = |norm.mant_main[norm_pkg::MANT_W-norm_pkg::MANT_W_H-3:0];
    end
    else
    begin
      upper  = norm.mant_main;
      ulp    = {{norm_pkg::MANT_W{1'b0}}, 1'b1};
      lsb    = norm.mant_main[0];
      guard  = norm.mant_tail[norm_pkg::TAIL_W-1];
      rbit   = norm.mant_tail[norm_pkg::TAIL_W-2];
      sticky = |norm.mant_tail[norm_pkg::TAIL_W-3:0];
    end
  end

  assign inexact = guard | rbit | sticky;  // Any dropped bit

  ////////////////////////////////////////////////////////////
  // Round-up decision
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (rm)
      norm_pkg::RM_NEAREST:  round_up = guard & (rbit | sticky | lsb);  // Ties to even
      norm_pkg::RM_TRUNC:    round_up = 1'b0;
      norm_pkg::RM_PLUSINF:  round_up = inexact & ~norm.sign;
      norm_pkg::RM_MINUSINF: round_up = inexact & norm.sign;
      default:               round_up = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Increment and carry renormalization
  ////////////////////////////////////////////////////////////
  assign sum   = {1'b0, upper} + {1'b0, (round_up ? ulp : '0)};
  assign carry = sum[norm_pkg::MAIN_W];

  always_comb
  begin
    rnd.sign    = norm.sign;
    rnd.exp     = norm.exp + {{(norm_pkg::EXP_W-1){1'b0}}, carry};
    rnd.frac    = carry ? sum[norm_pkg::MANT_W:1] : sum[norm_pkg::MANT_W-1:0];
    rnd.inexact = inexact;
    rnd.uf      = norm.uf;
    rnd.of      = norm.of;
  end

endmodule

// File: verilog/result_pack.sv
////////////////////////////////////////////////////////////
// FP16 results are NaN-boxed, upper half all ones
////////////////////////////////////////////////////////////

module result_pack (
  input  norm_pkg::special_t   spec,
  input  norm_pkg::round_out_t rnd,
  input  logic                 fp16,
  output norm_pkg::norm_res_t  res
);

  logic                        sign;
  logic [norm_pkg::EXP_W-1:0]  exp;
  logic [norm_pkg::MANT_W-1:0] frac;

  // Special encoding or rounded datapath
  always_comb
  begin
    res.fflags = '0;
    if (spec.active)
    begin
      sign = spec.sign;
      exp  = (spec.nan || spec.inf) ? '1 : '0;  // Zero otherwise
      frac = spec.nan ? norm_pkg::MANT_NAN : '0;
      res.fflags[norm_pkg::FLAG_NV] = spec.nv;
      res.fflags[norm_pkg::FLAG_DZ] = spec.dz;
      res.fflags[norm_pkg::FLAG_OF] = spec.of;
    end
    else
    begin
      sign = rnd.sign;
      exp  = rnd.exp;
      frac = rnd.frac;
      res.fflags[norm_pkg::FLAG_OF] = rnd.of;
      res.fflags[norm_pkg::FLAG_UF] = rnd.uf;
      res.fflags[norm_pkg::FLAG_NX] = rnd.inexact;
    end
  end

  // Format assembly
  always_comb
  begin
    if (fp16)
      res.result = {{norm_pkg::HALF_W{1'b1}}, sign,
                    exp[norm_pkg::EXP_W_H-1:0],
                    frac[norm_pkg::MANT_W-1 -: norm_pkg::MANT_W_H]};
    else
      res.result = {sign, exp, frac};
  end

endmodule

// File: verilog/norm_round_top.sv
////////////////////////////////////////////////////////////
// Two-cycle latency, one request per cycle, no back-pressure
// Receiver must take out_res on the cycle out_valid is high
////////////////////////////////////////////////////////////

module norm_round_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  norm_pkg::norm_req_t in_req,
  output logic                out_valid,
  output norm_pkg::norm_res_t out_res
);

  logic                 req_valid;  // Registered request
  norm_pkg::norm_req_t  req;
  norm_pkg::special_t   spec;
  norm_pkg::norm_out_t  norm;
  norm_pkg::round_out_t rnd;
  norm_pkg::norm_res_t  res;

  ////////////////////////////////////////////////////////////
  // Input stage
  ////////////////////////////////////////////////////////////
  pipe_stage #(.payload_t(norm_pkg::norm_req_t)) u_req_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (in_valid),
    .data_in   (in_req),
    .valid_out (req_valid),
    .data_out  (req)
  );

  // Combinational core
  special_case_check u_special (.req(req), .spec(spec));

  norm_shift u_shift (.req(req), .norm(norm));

  round_unit u_round (.norm(norm), .rm(req.rm), .fp16(req.fp16), .rnd(rnd));

  result_pack u_pack (.spec(spec), .rnd(rnd), .fp16(req.fp16), .res(res));

  ////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////
  pipe_stage #(.payload_t(norm_pkg::norm_res_t)) u_res_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (req_valid),
    .data_in   (res),
    .valid_out (out_valid),
    .data_out  (out_res)
  );

endmodule

// File: sim/norm_round_ref.svh
////////////////////////////////////////////////////////////
// Expected result from the normalize and round rules alone
// Exponent must already be biased for the request's format
////////////////////////////////////////////////////////////
`ifndef NORM_ROUND_REF_SVH
`define NORM_ROUND_REF_SVH

function automatic norm_pkg::norm_res_t norm_round_model(input norm_pkg::norm_req_t r);
  norm_pkg::norm_res_t res;
  logic [28:0] sig;     // 24 kept bits, 5 below
  logic [27:0] lost;    // Shifted past the tail
  logic [24:0] kept;
  logic [22:0] frac;
  logic [7:0]  e;
  logic [2:0]  sflags;  // NV DZ OF
  logic        div;
  logic        s;
  logic        uf;
  logic        of;
  logic        g;
  logic        rb;
  logic        st;
  logic        up;
  logic        nx;
  int          ev;
  int          sh;
  int          kind;    // 0 numeric, 1 NaN, 2 infinity, 3 zero

  ////////////////////////////////////////////////////////////
  // Special cases, first match wins
  ////////////////////////////////////////////////////////////
  div    = ~r.op_sqrt;
  kind   = 0;
  sflags = 3'b000;
  if (r.cls.nan_a || (div && r.cls.nan_b))
  begin
    kind   = 1;
    sflags = {r.cls.snan, 2'b00};  // Quiet NaN raises nothing
  end
  else if (r.cls.inf_a)
  begin
    kind   = ((div && r.cls.inf_b) || (r.op_sqrt && r.sign)) ? 1 : 2;
    sflags = (kind == 1) ? 3'b100 : 3'b001;
  end
  else if (div && r.cls.inf_b)
  begin
    kind   = 3;
    sflags = 3'b001;  // x/inf still flags OF
  end
  else if (r.cls.zero_a)
  begin
    kind   = (div && r.cls.zero_b) ? 1 : 3;
    sflags = (kind == 1) ? 3'b110 : 3'b000;
  end
  else if (div && r.cls.zero_b)
  begin
    kind   = 2;
    sflags = 3'b010;
  end
  else if (r.op_sqrt && r.sign)
  begin
    kind   = 1;
    sflags = 3'b100;
  end

  // Exponent range
  ev  = $signed(r.exp);
  sig = '0;
  e   = '0;
  uf  = 1'b0;
  of  = 1'b0;
  if (ev == 0)
  begin
    sig = {1'b0, r.mant};  // Denormal, one place right
    uf  = |r.mant;
  end
  else if ((ev == 1) && !r.mant[27])
  begin
    sig = {r.mant, 1'b0};
    uf  = 1'b1;
  end
  else if (ev < 0)
  begin
    sh   = 1 - ev;
    lost = (sh >= 28) ? r.mant : (r.mant & ((28'd1 << sh) - 28'd1));
    sig  = {r.mant >> sh, |lost};
    uf   = 1'b1;
  end
  else if (ev >= (r.fp16 ? 31 : 255))
  begin
    e  = 8'hff;  // Infinity
    of = 1'b1;
  end
  else if (!r.mant[27])
  begin
    sig = {r.mant[26:0], 2'b00};  // 0.1xx
    e   = r.exp[7:0] - 8'd1;
  end
  else
  begin
    sig = {r.mant, 1'b0};
    e   = r.exp[7:0];
  end

  ////////////////////////////////////////////////////////////
  // Rounding at the format's last place
  ////////////////////////////////////////////////////////////
  if (r.fp16)
  begin
    kept = {14'd0, sig[28:18]};
    g    = sig[17];
    rb   = sig[16];
    st   = |sig[15:5];  // Tail bits play no part in FP16
  end
  else
  begin
    kept = {1'b0, sig[28:5]};
    g    = sig[4];
    rb   = sig[3];
    st   = |sig[2:0];
  end
  nx = g | rb | st;
  case (r.rm)
    norm_pkg::RM_NEAREST:  up = g & (rb | st | kept[0]);
    norm_pkg::RM_PLUSINF:  up = nx & ~r.sign;
    norm_pkg::RM_MINUSINF: up = nx & r.sign;
    default:               up = 1'b0;
  endcase
  kept = kept + up;
  if (r.fp16 ? kept[11] : kept[24])
    e = e + 8'd1;  // Carry past hidden bit, fraction wraps to zero
  frac = r.fp16 ? {kept[9:0], 13'd0} : kept[22:0];
  s    = r.sign;

  res.fflags = {2'b00, of, uf, nx};  // NV DZ OF UF NX
  if (kind != 0)
  begin
    res.fflags = {sflags, 2'b00};
    e          = (kind == 3) ? 8'h00 : 8'hff;
    frac       = (kind == 1) ? norm_pkg::MANT_NAN : '0;
    s          = (kind == 1) ? 1'b0 : r.sign;
  end
  res.result = r.fp16 ? {16'hffff, s, e[4:0], frac[22:13]} : {s, e, frac};
  return res;
endfunction

`endif

// File: sim/norm_round_tb.sv
////////////////////////////////////////////////////////////
// Self-checking testbench, fixed seed, watchdog bounded
////////////////////////////////////////////////////////////

module norm_round_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_SPEC   = 24;  // Directed special cases
  localparam int N_SWEEP  = 64;  // Per format
  localparam int N_EDGE   = 32;
  localparam int N_STREAM = 240;
  localparam int N_TOTAL  = N_SPEC + 2 * N_SWEEP + N_EDGE + N_STREAM;
  localparam int WD_NS    = (N_TOTAL + 50) * 4 * 2;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  norm_pkg::norm_req_t in_req;
  logic                out_valid;
  norm_pkg::norm_res_t out_res;

  integer              seed;
  int                  cycle;     // Rising edges so far
  int                  n_pass;
  int                  n_fail;
  norm_pkg::norm_res_t exp_q[$];  // Expected, in request order
  int                  due_q[$];  // Cycle each result is due
  norm_pkg::norm_res_t exp_res;
  int                  due;

  `include "norm_round_ref.svh"

  norm_round_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(posedge clk)
    cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_result(input string name, input norm_pkg::norm_res_t expv,
                              input norm_pkg::norm_res_t actv);
    if (actv.result === expv.result)
      n_pass++;
    else
    begin
      n_fail++;
      $display("ERR %s exp 0x%08h got 0x%08h", name, expv.result, actv.result);
    end
  endtask

  task automatic check_flags(input string name, input logic [4:0] expv,
                             input logic [4:0] actv);
    if (actv === expv)
      n_pass++;
    else
    begin
      n_fail++;
      $display("ERR %s exp 0x%02h got 0x%02h", name, expv, actv);
    end
  endtask

  // Stimulus helpers
  function automatic norm_pkg::norm_req_t make_req(input logic [27:0] mant, input int e,
      input logic sign, input logic op_sqrt, input logic fp16, input logic [2:0] rm,
      input logic [6:0] cls);
    norm_pkg::norm_req_t r;
    r.mant    = mant;
    r.exp     = e[norm_pkg::EXP_IN_W-1:0];
    r.sign    = sign;
    r.op_sqrt = op_sqrt;
    r.fp16    = fp16;
    r.rm      = rm;
    r.cls     = cls;  // nan_a nan_b snan inf_a inf_b zero_a zero_b
    return r;
  endfunction

  function automatic logic [27:0] rand_mant(input logic half);
    logic [27:0] m;
    m = 28'($random(seed));
    if (half)
      m[27:26] = 2'b01;  // 0.1xx
    else
      m[27] = 1'b1;      // 1.xxx
    return m;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic send_req(input norm_pkg::norm_req_t r);
    @(negedge clk);
    in_valid = 1'b1;
    in_req   = r;
    exp_q.push_back(norm_round_model(r));
    due_q.push_back(cycle + 2);  // Seen at the negedge two rising edges on
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid    = 1'b0;
    in_req.mant = 28'($random(seed));  // Junk payload, must not surface
  endtask

  task automatic drain_and_report(input string name, input int n_req, input int fail0);
    @(negedge clk);
    in_valid = 1'b0;
    while (due_q.size() != 0)
      @(negedge clk);
    @(negedge clk);
    $display("%-12s %0d requests, %0d failures", name, n_req, n_fail - fail0);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic special_tests();
    logic [6:0] pats [12];
    int         fail0;
    pats  = '{7'b1000000, 7'b1010000, 7'b0100000, 7'b0110000, 7'b0001100, 7'b0001000,
              7'b0001000, 7'b0000100, 7'b0000011, 7'b0000010, 7'b0000001, 7'b0000000};
    fail0 = n_fail;
    for (int op = 0; op < 2; op++)
      for (int i = 0; i < 12; i++)
        send_req(make_req(rand_mant(1'b0), rand_range(2, 28), i[0], op[0], i[1],
                          3'(i % 4), pats[i]));
    drain_and_report("special", N_SPEC, fail0);
  endtask

  task automatic format_sweep(input logic fp16);
    logic [27:0] m;
    int          fail0;
    fail0 = n_fail;
    for (int i = 0; i < N_SWEEP; i++)
    begin
      m = rand_mant(i[2]);
      if (i % 16 < 4)
        m = i[4] ? 28'h7ffffff : 28'hfffffff;  // All ones, carry renormalizes
      send_req(make_req(m, fp16 ? rand_range(2, 30) : rand_range(2, 254),
                        1'($random(seed)), 1'($random(seed)), fp16, 3'(i % 4), 7'd0));
    end
    drain_and_report(fp16 ? "fp16 sweep" : "fp32 sweep", N_SWEEP, fail0);
  endtask

  task automatic exponent_edges();
    int exps [16];
    int fail0;
    exps  = '{0, 0, 1, 1, -1, -4, -12, -22, -27, -40, -300, 30, 31, 40, 255, 300};
    fail0 = n_fail;
    for (int f = 0; f < 2; f++)
      for (int i = 0; i < 16; i++)
        send_req(make_req((i == 0) ? 28'd0 : rand_mant(i[0]), exps[i], 1'($random(seed)),
                          1'b0, f[0], 3'(i % 4), 7'd0));
    drain_and_report("exp edges", N_EDGE, fail0);
  endtask

  task automatic stream_mix();
    logic [6:0] cls;
    int         fail0;
    fail0 = n_fail;
    for (int i = 0; i < N_STREAM; i++)
    begin
      if (($random(seed) & 7) == 0)
        idle_cycle();  // Gap
      cls = (($random(seed) & 3) == 0) ? 7'($random(seed)) : 7'd0;
      send_req(make_req(rand_mant(1'($random(seed))), rand_range(0, 300) - 40,
                        1'($random(seed)), 1'($random(seed)), 1'($random(seed)),
                        3'(rand_range(0, 3)), cls));
    end
    drain_and_report("stream", N_STREAM, fail0);
  endtask

  ////////////////////////////////////////////////////////////
  // Output compare, one result per out_valid
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (out_valid)
      begin
        if (exp_q.size() == 0)
        begin
          n_fail++;
          $display("Output arrived at cycle %0d with no request pending", cycle);
        end
        else
        begin
          exp_res = exp_q.pop_front();
          due     = due_q.pop_front();
          if (due != cycle)
          begin
            n_fail++;
            $display("Output arrived at cycle %0d but was due at cycle %0d", cycle, due);
          end
          check_result("out_res.result", exp_res, out_res);
          check_flags("out_res.fflags", exp_res.fflags, out_res.fflags);
        end
      end
      else if ((due_q.size() != 0) && (due_q[0] <= cycle))
      begin
        n_fail++;
        $display("Output due at cycle %0d never arrived", due_q[0]);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  // Watchdog
  initial
  begin
    #(WD_NS);
    $display("Watchdog expired after %0d ns, %0d results outstanding", WD_NS, due_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    seed     = 32'h5dc5;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;
    n_pass   = 0;
    n_fail   = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (out_valid !== 1'b0)
    begin
      n_fail++;
      $display("ERR out_valid exp 0x0 got 0x%0h", out_valid);
    end
    check_result("out_res.result", '0, out_res);
    check_flags("out_res.fflags", 5'd0, out_res.fflags);
    $display("%-12s %0d failures", "reset", n_fail);

    special_tests();
    format_sweep(1'b0);
    format_sweep(1'b1);
    exponent_edges();
    stream_mix();

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: src.f
+incdir+sim
verilog/norm_pkg.sv
verilog/pipe_stage.sv
verilog/special_case_check.sv
verilog/norm_shift.sv
verilog/round_unit.sv
verilog/result_pack.sv
verilog/norm_round_top.sv
sim/norm_round_tb.sv
